// File: src.f
verilog/axi_ni_pkg.sv
verilog/ni_fifo.sv
verilog/rx_vc_buffers.sv
verilog/axi_wr_chan.sv
verilog/axi_rd_chan.sv
verilog/axi_ni_slave.sv
sim/axi_ni_sva.sv
sim/tb_axi_ni.sv

// File: Makefile
TOP := tb_axi_ni

.PHONY: sim clean

sim:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f src.f
	out=$$(./obj_dir/V$(TOP)); echo "$$out"; echo "$$out" | grep -qx "All tests passed"

clean:
	rm -rf obj_dir

// File: sim/tb_axi_ni.sv
// Testbench for the AXI NI slave, runs write, read and NoC traffic against scoreboards
`timescale 1ns/1ps

module tb_axi_ni
  import axi_ni_pkg::*;
();
  localparam int NUM_VC         = 4;
  localparam int OT_DEPTH       = 4;
  localparam int VC_DEPTH       = 4;
  localparam int TIMEOUT_CYCLES = 200;
  localparam int DRAIN_CYCLES   = 2000;

  // Expected R beat, data comes from the NoC model when the beat arrives
  typedef struct packed {
    logic [AxiIdWidth-1:0] id;
    logic [MaxVcWidth-1:0] vc;
    logic                  err;
    logic                  last;
  } exp_beat_t;

  logic     clk_axi;
  logic     arst_axi;
  axi_aw_t  aw_i;
  logic     awvalid_i;
  logic     awready_o;
  axi_w_t   w_i;
  logic     wvalid_i;
  logic     wready_o;
  axi_b_t   b_o;
  logic     bvalid_o;
  logic     bready_i;
  axi_ar_t  ar_i;
  logic     arvalid_i;
  logic     arready_o;
  axi_r_t   r_o;
  logic     rvalid_o;
  logic     rready_i;
  pkt_out_t pkt_out_o;
  logic     pkt_ready_i;
  pkt_in_t  pkt_in_i;
  logic     pkt_in_ready_o;

  // Scoreboards
  pkt_out_t  flit_q[$];
  axi_b_t    b_q[$];
  exp_beat_t beat_q[$];
  pkt_in_t   noc_q[$];

  logic [15:0] lfsr_q;
  logic        bp_en;
  int          mismatch_cnt;
  int          extra_cnt;
  int          timeout_cnt;
  int          sva_cnt;

  axi_ni_slave #(
    .NUM_VC   (NUM_VC),
    .OT_DEPTH (OT_DEPTH),
    .VC_DEPTH (VC_DEPTH)
  ) uut (
    .clk_axi        (clk_axi),
    .arst_axi       (arst_axi),
    .aw_i           (aw_i),
    .awvalid_i      (awvalid_i),
    .awready_o      (awready_o),
    .w_i            (w_i),
    .wvalid_i       (wvalid_i),
    .wready_o       (wready_o),
    .b_o            (b_o),
    .bvalid_o       (bvalid_o),
    .bready_i       (bready_i),
    .ar_i           (ar_i),
    .arvalid_i      (arvalid_i),
    .arready_o      (arready_o),
    .r_o            (r_o),
    .rvalid_o       (rvalid_o),
    .rready_i       (rready_i),
    .pkt_out_o      (pkt_out_o),
    .pkt_ready_i    (pkt_ready_i),
    .pkt_in_i       (pkt_in_i),
    .pkt_in_ready_o (pkt_in_ready_o)
  );

  always #4 clk_axi = ~clk_axi;

  // ************************************************************
  // Helpers
  // ************************************************************
  // Galois LFSR, one step per bit handed out
  function automatic logic [63:0] rand_bits(input int n);
    logic [63:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_q = lfsr_q[0] ? ((lfsr_q >> 1) ^ 16'hB400) : (lfsr_q >> 1);
      v = {v[62:0], lfsr_q[0]};
    end
    return v;
  endfunction

  task automatic check_value(input string name, input logic [AxiDataWidth-1:0] got,
                             input logic [AxiDataWidth-1:0] exp);
    assert (got === exp) else begin
      mismatch_cnt++;
      $display("mismatch at %0t ns: %s expected %0h got %0h", $time, name, exp, got);
    end
  endtask

  task automatic report_timeout(input string what);
    timeout_cnt++;
    $display("timeout at %0t ns: %s did not finish within its wait limit", $time, what);
  endtask

  task automatic check_reset_outputs();
    check_value("awready_o", awready_o, 0);
    check_value("arready_o", arready_o, 0);
    check_value("wready_o", wready_o, 0);
    check_value("bvalid_o", bvalid_o, 0);
    check_value("rvalid_o", rvalid_o, 0);
    check_value("pkt_out_o.valid", pkt_out_o.valid, 0);
  endtask

  // ************************************************************
  // Stimulus tasks, entered and left 1 ns after a rising edge
  // ************************************************************
  task automatic write_burst(input int id, input logic [AxiAddrWidth-1:0] addr, input int len,
                             input logic [2:0] size, input axi_burst_e burst,
                             input logic bad, input int vc);
    logic [AxiDataWidth-1:0] data;
    pkt_out_t                flit;
    axi_b_t                  b;
    int                      cycles;
    aw_i.id    = AxiIdWidth'(id);
    aw_i.addr  = addr;
    aw_i.len   = AxiLenWidth'(len);
    aw_i.size  = size;
    aw_i.burst = burst;
    awvalid_i  = 1'b1;
    cycles     = 0;
    do begin
      @(posedge clk_axi);
      cycles++;
    end while (!awready_o && cycles < TIMEOUT_CYCLES);
    if (!awready_o) report_timeout("AW handshake");
    #1;
    awvalid_i = 1'b0;
    b.id      = AxiIdWidth'(id);
    b.resp    = bad ? RESP_SLVERR : RESP_OKAY;
    b_q.push_back(b);
    for (int i = 0; i <= len; i++) begin
      data       = rand_bits(64);
      w_i.data   = data;
      w_i.last   = (i == len);
      wvalid_i   = 1'b1;
      // Bad bursts are swallowed, no flit expected
      if (!bad) begin
        flit.valid = 1'b1;
        flit.vc    = MaxVcWidth'(vc);
        flit.head  = (i == 0);
        flit.last  = (i == len);
        flit.len   = AxiLenWidth'(len);
        flit.data  = data;
        flit_q.push_back(flit);
      end
      cycles = 0;
      do begin
        @(posedge clk_axi);
        cycles++;
      end while (!wready_o && cycles < TIMEOUT_CYCLES);
      if (!wready_o) report_timeout("W beat handshake");
      #1;
    end
    wvalid_i = 1'b0;
  endtask

  task automatic read_burst(input int id, input logic [AxiAddrWidth-1:0] addr, input int len,
                            input axi_burst_e burst, input logic bad, input int vc);
    exp_beat_t eb;
    int        cycles;
    ar_i.id    = AxiIdWidth'(id);
    ar_i.addr  = addr;
    ar_i.len   = AxiLenWidth'(len);
    ar_i.size  = 3'd3;
    ar_i.burst = burst;
    arvalid_i  = 1'b1;
    cycles     = 0;
    do begin
      @(posedge clk_axi);
      cycles++;
    end while (!arready_o && cycles < TIMEOUT_CYCLES);
    if (!arready_o) report_timeout("AR handshake");
    #1;
    arvalid_i = 1'b0;
    for (int i = 0; i <= len; i++) begin
      eb.id   = AxiIdWidth'(id);
      eb.vc   = MaxVcWidth'(vc);
      eb.err  = bad;
      eb.last = (i == len);
      beat_q.push_back(eb);
    end
  endtask

  task automatic push_flits(input int vc, input int n);
    int cycles;
    for (int i = 0; i < n; i++) begin
      pkt_in_i.valid = 1'b1;
      pkt_in_i.vc    = MaxVcWidth'(vc);
      pkt_in_i.data  = rand_bits(64);
      cycles         = 0;
      do begin
        @(posedge clk_axi);
        cycles++;
      end while (!pkt_in_ready_o && cycles < TIMEOUT_CYCLES);
      if (!pkt_in_ready_o) report_timeout("NoC flit push");
      #1;
    end
    pkt_in_i.valid = 1'b0;
  endtask

  task automatic wait_drain();
    int cycles;
    cycles = 0;
    while ((flit_q.size() + b_q.size() + beat_q.size()) != 0 && cycles < DRAIN_CYCLES) begin
      @(posedge clk_axi);
      cycles++;
    end
    if ((flit_q.size() + b_q.size() + beat_q.size()) != 0) begin
      report_timeout("drain of pending flits and responses");
    end
    @(posedge clk_axi);
    #1;
  endtask

  // ************************************************************
  // Ready patterns and monitors
  // ************************************************************
  // Readies high three times in four under back-pressure
  always @(posedge clk_axi) begin
    logic [5:0] draw;
    draw = '1;
    if (bp_en) begin
      draw = 6'(rand_bits(6));
    end
    #1;
    pkt_ready_i = (draw[5:4] != 0);
    bready_i    = (draw[3:2] != 0);
    rready_i    = (draw[1:0] != 0);
  end

  // Flits accepted into the DUT, in arrival order
  always @(posedge clk_axi) begin
    if (!arst_axi && pkt_in_i.valid && pkt_in_ready_o) begin
      noc_q.push_back(pkt_in_i);
    end
  end

  always @(posedge clk_axi) begin
    pkt_out_t ef;
    if (!arst_axi && pkt_out_o.valid && pkt_ready_i) begin
      assert (flit_q.size() > 0) else begin
        extra_cnt++;
        $display("error at %0t ns: flit on pkt_out_o with no write beat pending", $time);
      end
      if (flit_q.size() > 0) begin
        ef = flit_q.pop_front();
        check_value("pkt_out_o.vc", pkt_out_o.vc, ef.vc);
        check_value("pkt_out_o.head", pkt_out_o.head, ef.head);
        check_value("pkt_out_o.last", pkt_out_o.last, ef.last);
        check_value("pkt_out_o.len", pkt_out_o.len, ef.len);
        check_value("pkt_out_o.data", pkt_out_o.data, ef.data);
      end
    end
  end

  always @(posedge clk_axi) begin
    axi_b_t eb;
    if (!arst_axi && bvalid_o && bready_i) begin
      assert (b_q.size() > 0) else begin
        extra_cnt++;
        $display("error at %0t ns: write response with no burst pending", $time);
      end
      if (b_q.size() > 0) begin
        eb = b_q.pop_front();
        check_value("b_o.id", b_o.id, eb.id);
        check_value("b_o.resp", b_o.resp, eb.resp);
      end
    end
  end

  always @(posedge clk_axi) begin
    exp_beat_t               eb;
    logic [AxiDataWidth-1:0] exp_data;
    int                      idx;
    if (!arst_axi && rvalid_o && rready_i) begin
      assert (beat_q.size() > 0) else begin
        extra_cnt++;
        $display("error at %0t ns: read beat with no read burst pending", $time);
      end
      if (beat_q.size() > 0) begin
        eb       = beat_q.pop_front();
        exp_data = '0;
        idx      = -1;
        // Oldest flit of the addressed VC
        if (!eb.err) begin
          for (int i = 0; i < noc_q.size(); i++) begin
            if (idx < 0 && noc_q[i].vc == eb.vc) idx = i;
          end
          assert (idx >= 0) else begin
            extra_cnt++;
            $display("error at %0t ns: read beat from VC %0d that holds no flit", $time, eb.vc);
          end
          if (idx >= 0) begin
            exp_data = noc_q[idx].data;
            noc_q.delete(idx);
          end
        end
        check_value("r_o.id", r_o.id, eb.id);
        check_value("r_o.data", r_o.data, exp_data);
        check_value("r_o.resp", r_o.resp, eb.err ? RESP_SLVERR : RESP_OKAY);
        check_value("r_o.last", r_o.last, eb.last);
      end
    end
  end

  // ************************************************************
  // Test sequence
  // ************************************************************
  initial begin
    clk_axi      = 1'b0;
    arst_axi     = 1'b1;
    aw_i         = '0;
    awvalid_i    = 1'b0;
    w_i          = '0;
    wvalid_i     = 1'b0;
    bready_i     = 1'b1;
    ar_i         = '0;
    arvalid_i    = 1'b0;
    rready_i     = 1'b1;
    pkt_in_i     = '0;
    pkt_ready_i  = 1'b1;
    bp_en        = 1'b0;
    lfsr_q       = 16'd18;
    mismatch_cnt = 0;
    extra_cnt    = 0;
    timeout_cnt  = 0;

    repeat (4) begin
      @(posedge clk_axi);
      check_reset_outputs();
    end
    #1;
    arst_axi = 1'b0;
    // Still quiet in the first cycle out of reset, then both queues open
    @(posedge clk_axi);
    check_reset_outputs();
    @(posedge clk_axi);
    check_value("awready_o", awready_o, 1);
    check_value("arready_o", arready_o, 1);
    #1;

    // Good writes to each VC, then the bad ones
    for (int k = 0; k < NUM_VC; k++) begin
      write_burst(k, WrVcBase + AxiAddrWidth'(k * VcStride), k + 1, 3'd3, BURST_INCR, 0, k);
    end
    write_burst(5, WrVcBase, 2, 3'd3, BURST_WRAP, 1, 0);
    write_burst(6, WrVcBase + 16'd8, 1, 3'd2, BURST_INCR, 1, 0);
    write_burst(7, 16'h1004, 0, 3'd3, BURST_INCR, 1, 0);
    write_burst(8, RdVcBase, 1, 3'd3, BURST_INCR, 1, 0);
    wait_drain();

    // Reads with flits already buffered
    for (int k = 0; k < NUM_VC; k++) begin
      push_flits(k, k + 1);
      read_burst(k, RdVcBase + AxiAddrWidth'(k * VcStride), k, BURST_INCR, 0, k);
    end
    // Read waits for flits that come later
    read_burst(9, RdVcBase + 16'd8, 2, BURST_INCR, 0, 1);
    push_flits(1, 3);
    read_burst(10, 16'h3000, 3, BURST_INCR, 1, 0);
    read_burst(11, RdVcBase + 16'd32, 1, BURST_INCR, 1, 0);
    read_burst(12, RdVcBase, 2, BURST_WRAP, 1, 0);
    wait_drain();

    // Random back-pressure on all three ready inputs
    bp_en = 1'b1;
    for (int n = 0; n < 8; n++) begin
      write_burst(n, WrVcBase + AxiAddrWidth'((n % NUM_VC) * VcStride), 3, 3'd3, BURST_INCR,
                  0, n % NUM_VC);
      push_flits(n % NUM_VC, 2);
      read_burst(n, RdVcBase + AxiAddrWidth'((n % NUM_VC) * VcStride), 1, BURST_INCR, 0,
                 n % NUM_VC);
    end
    write_burst(13, 16'h1100, 2, 3'd3, BURST_INCR, 1, 0);
    read_burst(14, 16'h2100, 2, BURST_INCR, 1, 0);
    wait_drain();
    bp_en = 1'b0;

    // Full VC buffer stalls the NoC until a read frees a slot
    push_flits(2, VC_DEPTH);
    pkt_in_i.valid = 1'b1;
    pkt_in_i.vc    = 2'd2;
    pkt_in_i.data  = rand_bits(64);
    repeat (3) begin
      @(posedge clk_axi);
      check_value("pkt_in_ready_o", pkt_in_ready_o, 0);
    end
    #1;
    pkt_in_i.valid = 1'b0;
    fork
      read_burst(15, RdVcBase + 16'd16, VC_DEPTH, BURST_INCR, 0, 2);
      push_flits(2, 1);
    join
    wait_drain();
    repeat (4) @(posedge clk_axi);

    sva_cnt = int'(uut.u_sva.fail_count);
    $display("errors: mismatch %0d, unexpected %0d, timeout %0d, assertion %0d",
             mismatch_cnt, extra_cnt, timeout_cnt, sva_cnt);
    if (mismatch_cnt + extra_cnt + timeout_cnt + sva_cnt == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

endmodule

// File: sim/axi_ni_sva.sv
// Concurrent AXI and NoC handshake checks, attached to the NI slave top by bind
`timescale 1ns/1ps

module axi_ni_sva
  import axi_ni_pkg::*;
(
  input logic     clk_axi,
  input logic     arst_axi,
  input logic     awready_o,
  input logic     arready_o,
  input logic     wready_o,
  input axi_b_t   b_o,
  input logic     bvalid_o,
  input logic     bready_i,
  input axi_r_t   r_o,
  input logic     rvalid_o,
  input logic     rready_i,
  input pkt_out_t pkt_out_o,
  input logic     pkt_ready_i
);
  // Failed assertions so far, read by the testbench at the end
  int unsigned fail_count = 0;

  // ************************************************************
  // Hold rules while the receiver stalls
  // ************************************************************
  b_hold: assert property (@(posedge clk_axi) disable iff (arst_axi)
    bvalid_o && !bready_i |=> bvalid_o && $stable(b_o))
  else begin
    fail_count++;
    $error("bvalid_o dropped or b_o changed before bready_i");
  end

  r_hold: assert property (@(posedge clk_axi) disable iff (arst_axi)
    rvalid_o && !rready_i |=> rvalid_o && $stable(r_o))
  else begin
    fail_count++;
    $error("rvalid_o dropped or r_o changed while rready_i was low");
  end

  // Flit payload frozen during packet generator back-pressure
  pkt_hold: assert property (@(posedge clk_axi) disable iff (arst_axi)
    pkt_out_o.valid && !pkt_ready_i |=> $stable(pkt_out_o))
  else begin
    fail_count++;
    $error("pkt_out_o changed while pkt_ready_i was low");
  end

  rlast_valid: assert property (@(posedge clk_axi) disable iff (arst_axi)
    r_o.last |-> rvalid_o)
  else begin
    fail_count++;
    $error("rlast seen without rvalid_o");
  end

  // ************************************************************
  // Quiet outputs in reset
  // ************************************************************
  reset_quiet: assert property (@(posedge clk_axi)
    arst_axi |-> !awready_o && !arready_o && !wready_o && !bvalid_o && !rvalid_o
                 && !pkt_out_o.valid)
  else begin
    fail_count++;
    $error("handshake output high during reset");
  end

endmodule

bind axi_ni_slave axi_ni_sva u_sva (
  .clk_axi     (clk_axi),
  .arst_axi    (arst_axi),
  .awready_o   (awready_o),
  .arready_o   (arready_o),
  .wready_o    (wready_o),
  .b_o         (b_o),
  .bvalid_o    (bvalid_o),
  .bready_i    (bready_i),
  .r_o         (r_o),
  .rvalid_o    (rvalid_o),
  .rready_i    (rready_i),
  .pkt_out_o   (pkt_out_o),
  .pkt_ready_i (pkt_ready_i)
);

// File: verilog/axi_ni_slave.sv
// AXI4 slave network interface top, joins the independent write and read channels
`timescale 1ns/1ps

module axi_ni_slave
  import axi_ni_pkg::*;
#(
  parameter int NUM_VC   = 4,
  parameter int OT_DEPTH = 4,
  parameter int VC_DEPTH = 4
) (
  input  logic     clk_axi,
  input  logic     arst_axi,
  // AXI write address, data and response
  input  axi_aw_t  aw_i,
  input  logic     awvalid_i,
  output logic     awready_o,
  input  axi_w_t   w_i,
  input  logic     wvalid_i,
  output logic     wready_o,
  output axi_b_t   b_o,
  output logic     bvalid_o,
  input  logic     bready_i,
  // AXI read address and data
  input  axi_ar_t  ar_i,
  input  logic     arvalid_i,
  output logic     arready_o,
  output axi_r_t   r_o,
  output logic     rvalid_o,
  input  logic     rready_i,
  // NoC side
  output pkt_out_t pkt_out_o,
  input  logic     pkt_ready_i,
  input  pkt_in_t  pkt_in_i,
  output logic     pkt_in_ready_o
);

  // ***********************************************************
  // Write side toward the packet generator
  // ***********************************************************
  axi_wr_chan #(
    .NUM_VC   (NUM_VC),
    .OT_DEPTH (OT_DEPTH)
  ) u_wr_chan (
    .clk_axi     (clk_axi),
    .arst_axi    (arst_axi),
    .aw_i        (aw_i),
    .awvalid_i   (awvalid_i),
    .awready_o   (awready_o),
    .w_i         (w_i),
    .wvalid_i    (wvalid_i),
    .wready_o    (wready_o),
    .b_o         (b_o),
    .bvalid_o    (bvalid_o),
    .bready_i    (bready_i),
    .pkt_out_o   (pkt_out_o),
    .pkt_ready_i (pkt_ready_i)
  );

  // Read side fed by flits from the NoC
  axi_rd_chan #(
    .NUM_VC   (NUM_VC),
    .OT_DEPTH (OT_DEPTH),
    .VC_DEPTH (VC_DEPTH)
  ) u_rd_chan (
    .clk_axi        (clk_axi),
    .arst_axi       (arst_axi),
    .ar_i           (ar_i),
    .arvalid_i      (arvalid_i),
    .arready_o      (arready_o),
    .r_o            (r_o),
    .rvalid_o       (rvalid_o),
    .rready_i       (rready_i),
    .pkt_in_i       (pkt_in_i),
    .pkt_in_ready_o (pkt_in_ready_o)
  );

endmodule

// File: verilog/axi_rd_chan.sv
// AXI read channel of the NI slave, serves AR bursts from the per-VC receive buffers
`timescale 1ns/1ps

module axi_rd_chan
  import axi_ni_pkg::*;
#(
  parameter int NUM_VC   = 4,
  parameter int OT_DEPTH = 4,
  parameter int VC_DEPTH = 4
) (
  input  logic    clk_axi,
  input  logic    arst_axi,
  input  axi_ar_t ar_i,
  input  logic    arvalid_i,
  output logic    arready_o,
  output axi_r_t  r_o,
  output logic    rvalid_o,
  input  logic    rready_i,
  input  pkt_in_t pkt_in_i,
  output logic    pkt_in_ready_o
);
  ni_dec_t                 ar_dec;
  ot_entry_t               ot_in;
  ot_entry_t               ot_head;
  logic                    ot_full;
  logic                    ot_empty;
  logic                    ot_push;
  logic                    ot_pop;
  logic                    ready_q;
  logic                    err_q;
  logic [AxiLenWidth-1:0]  beat_q;
  logic [NUM_VC-1:0]       vc_empty;
  logic                    sel_empty;
  logic [AxiDataWidth-1:0] vc_data;
  logic                    vc_rd_en;
  logic                    r_hs;
  logic                    r_last;

  // ***********************************************************
  // AR decode and outstanding read queue
  // ***********************************************************
  always_comb begin
    ar_dec = decode_region(ar_i.addr, NUM_VC, ar_i.burst, ar_i.size);
    ot_in.id    = ar_i.id;
    ot_in.len   = ar_i.len;
    ot_in.vc    = ar_dec.vc;
    ot_in.error = (ar_dec.region != REGION_RD_VC);
  end

  assign arready_o = ready_q & ~ot_full;
  assign ot_push   = arvalid_i & arready_o;

  ni_fifo #(
    .DEPTH (OT_DEPTH),
    .WIDTH ($bits(ot_entry_t))
  ) u_ot_rd (
    .clk_axi  (clk_axi),
    .arst_axi (arst_axi),
    .write_i  (ot_push),
    .read_i   (ot_pop),
    .data_i   (ot_in),
    .data_o   (ot_head),
    .full_o   (ot_full),
    .empty_o  (ot_empty)
  );

  rx_vc_buffers #(
    .NUM_VC   (NUM_VC),
    .VC_DEPTH (VC_DEPTH)
  ) u_rx_vc_buffers (
    .clk_axi        (clk_axi),
    .arst_axi       (arst_axi),
    .pkt_in_i       (pkt_in_i),
    .pkt_in_ready_o (pkt_in_ready_o),
    .rd_vc_i        (ot_head.vc),
    .rd_en_i        (vc_rd_en),
    .rd_data_o      (vc_data),
    .empty_o        (vc_empty)
  );

  // ***********************************************************
  // R beat formation
  // ***********************************************************
  always_comb begin
    // Empty flag of the VC addressed by the head burst
    sel_empty = 1'b1;
    for (int i = 0; i < NUM_VC; i++) begin
      if (ot_head.vc == MaxVcWidth'(i)) begin
        sel_empty = vc_empty[i];
      end
    end

    // Valid bursts stream as flits arrive, error bursts run on err_q
    rvalid_o = (~ot_empty & ~ot_head.error & ~sel_empty) | err_q;
    r_last   = (beat_q == ot_head.len);
    r_hs     = rvalid_o & rready_i;
    vc_rd_en = r_hs & ~ot_head.error;
    ot_pop   = r_hs & r_last;

    r_o.id   = ot_head.id;
    r_o.data = ot_head.error ? '0 : vc_data;
    r_o.resp = ot_head.error ? RESP_SLVERR : RESP_OKAY;
    r_o.last = r_last & rvalid_o;
  end

  always_ff @(posedge clk_axi or posedge arst_axi) begin
    if (arst_axi) begin
      ready_q <= 1'b0;
      err_q   <= 1'b0;
      beat_q  <= '0;
    end else begin
      ready_q <= 1'b1;
      // Error beats start one cycle after the entry reaches the head
      err_q   <= ~ot_empty & ot_head.error & ~ot_pop;
      // Beat index within the current burst
      if (r_hs) begin
        beat_q <= r_last ? '0 : beat_q + 1'b1;
      end
    end
  end

endmodule

// File: verilog/axi_wr_chan.sv
// AXI write channel of the NI slave, turns AW/W bursts into flits and returns B responses
`timescale 1ns/1ps

module axi_wr_chan
  import axi_ni_pkg::*;
#(
  parameter int NUM_VC   = 4,
  parameter int OT_DEPTH = 4
) (
  input  logic     clk_axi,
  input  logic     arst_axi,
  input  axi_aw_t  aw_i,
  input  logic     awvalid_i,
  output logic     awready_o,
  input  axi_w_t   w_i,
  input  logic     wvalid_i,
  output logic     wready_o,
  output axi_b_t   b_o,
  output logic     bvalid_o,
  input  logic     bready_i,
  output pkt_out_t pkt_out_o,
  input  logic     pkt_ready_i
);
  ni_dec_t   aw_dec;
  ot_entry_t ot_in;
  ot_entry_t ot_head;
  logic      ot_full;
  logic      ot_empty;
  logic      ot_push;
  logic      ot_pop;
  logic      ready_q;
  logic      head_q;
  logic      w_hs;
  logic      bvalid_q;
  axi_b_t    b_q;

  // ***********************************************************
  // AW decode and outstanding write queue
  // ***********************************************************
  always_comb begin
    aw_dec = decode_region(aw_i.addr, NUM_VC, aw_i.burst, aw_i.size);
    ot_in.id    = aw_i.id;
    ot_in.len   = aw_i.len;
    ot_in.vc    = aw_dec.vc;
    // Writes outside the write VC region or bad bursts still queue, marked as error
    ot_in.error = (aw_dec.region != REGION_WR_VC);
  end

  // Accept AW only once out of reset and while the queue has room
  assign awready_o = ready_q & ~ot_full;
  assign ot_push   = awvalid_i & awready_o;

  ni_fifo #(
    .DEPTH (OT_DEPTH),
    .WIDTH ($bits(ot_entry_t))
  ) u_ot_wr (
    .clk_axi  (clk_axi),
    .arst_axi (arst_axi),
    .write_i  (ot_push),
    .read_i   (ot_pop),
    .data_i   (ot_in),
    .data_o   (ot_head),
    .full_o   (ot_full),
    .empty_o  (ot_empty)
  );

  // ***********************************************************
  // W beats to flits
  // ***********************************************************
  always_comb begin
    // Error bursts drain without waiting on the packet generator
    wready_o = ~ot_empty & ~bvalid_q & (ot_head.error | pkt_ready_i);
    w_hs     = wvalid_i & wready_o;
    // Last beat retires the burst from the queue
    ot_pop   = w_hs & w_i.last;

    pkt_out_o.valid = wvalid_i & ~ot_empty & ~bvalid_q & ~ot_head.error;
    pkt_out_o.vc    = ot_head.vc;
    pkt_out_o.head  = head_q;
    pkt_out_o.last  = w_i.last;
    pkt_out_o.len   = ot_head.len;
    pkt_out_o.data  = w_i.data;
  end

  // ***********************************************************
  // B response
  // ***********************************************************
  always_ff @(posedge clk_axi or posedge arst_axi) begin
    if (arst_axi) begin
      ready_q  <= 1'b0;
      head_q   <= 1'b1;
      bvalid_q <= 1'b0;
    end else begin
      ready_q <= 1'b1;
      // Next beat after a wlast opens a new packet
      if (w_hs) begin
        head_q <= w_i.last;
      end
      if (ot_pop) begin
        bvalid_q <= 1'b1;
      end else if (bready_i) begin
        bvalid_q <= 1'b0;
      end
    end
  end

  // Response captured with the burst being retired
  always_ff @(posedge clk_axi) begin
    if (ot_pop) begin
      b_q.id   <= ot_head.id;
      b_q.resp <= ot_head.error ? RESP_SLVERR : RESP_OKAY;
    end
  end

  assign b_o      = b_q;
  assign bvalid_o = bvalid_q;

endmodule

// File: verilog/rx_vc_buffers.sv
// Per-VC receive buffers fed from the NoC and drained by the AXI read channel
`timescale 1ns/1ps

module rx_vc_buffers
  import axi_ni_pkg::*;
#(
  parameter int NUM_VC   = 4,
  parameter int VC_DEPTH = 4
) (
  input  logic                    clk_axi,
  input  logic                    arst_axi,
  input  pkt_in_t                 pkt_in_i,
  output logic                    pkt_in_ready_o,
  input  logic [MaxVcWidth-1:0]   rd_vc_i,
  input  logic                    rd_en_i,
  output logic [AxiDataWidth-1:0] rd_data_o,
  output logic [NUM_VC-1:0]       empty_o
);
  logic [NUM_VC-1:0]                   vc_write;
  logic [NUM_VC-1:0]                   vc_read;
  logic [NUM_VC-1:0]                   vc_full;
  logic [NUM_VC-1:0][AxiDataWidth-1:0] vc_data;

  // ***********************************************************
  // Write steering and read selection
  // ***********************************************************
  always_comb begin
    pkt_in_ready_o = 1'b0;
    rd_data_o      = '0;
    for (int i = 0; i < NUM_VC; i++) begin
      // Flit enters its own VC only when that buffer has room
      vc_write[i] = pkt_in_i.valid & (pkt_in_i.vc == MaxVcWidth'(i)) & ~vc_full[i];
      vc_read[i]  = rd_en_i & (rd_vc_i == MaxVcWidth'(i));
      if (pkt_in_i.vc == MaxVcWidth'(i)) begin
        pkt_in_ready_o = ~vc_full[i];
      end
      if (rd_vc_i == MaxVcWidth'(i)) begin
        rd_data_o = vc_data[i];
      end
    end
  end

  // One buffer per VC
  for (genvar g = 0; g < NUM_VC; g++) begin : gen_vc_buf
    ni_fifo #(
      .DEPTH (VC_DEPTH),
      .WIDTH (AxiDataWidth)
    ) u_vc_fifo (
      .clk_axi  (clk_axi),
      .arst_axi (arst_axi),
      .write_i  (vc_write[g]),
      .read_i   (vc_read[g]),
      .data_i   (pkt_in_i.data),
      .data_o   (vc_data[g]),
      .full_o   (vc_full[g]),
      .empty_o  (empty_o[g])
    );
  end

endmodule

// File: verilog/ni_fifo.sv
// Synchronous circular FIFO with full and empty flags, for request queues and VC buffers
`timescale 1ns/1ps

module ni_fifo #(
  parameter int DEPTH = 4,
  parameter int WIDTH = 8
) (
  input  logic             clk_axi,
  input  logic             arst_axi,
  input  logic             write_i,
  input  logic             read_i,
  input  logic [WIDTH-1:0] data_i,
  output logic [WIDTH-1:0] data_o,
  output logic             full_o,
  output logic             empty_o
);
  localparam int PtrW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CntW = $clog2(DEPTH + 1);

  logic [WIDTH-1:0] mem [DEPTH];
  logic [PtrW-1:0]  wr_ptr;
  logic [PtrW-1:0]  rd_ptr;
  logic [CntW-1:0]  count;
  logic             do_write;
  logic             do_read;

  // Overflow and underflow requests are dropped
  assign do_write = write_i & ~full_o;
  assign do_read  = read_i & ~empty_o;

  assign full_o  = (count == CntW'(DEPTH));
  assign empty_o = (count == '0);
  // Head entry is visible without a read strobe
  assign data_o  = mem[rd_ptr];

  always_ff @(posedge clk_axi or posedge arst_axi) begin
    if (arst_axi) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_write) begin
        wr_ptr <= (wr_ptr == PtrW'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (do_read) begin
        rd_ptr <= (rd_ptr == PtrW'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
      // Simultaneous push and pop keeps the count
      if (do_write && !do_read) begin
        count <= count + 1'b1;
      end else if (do_read && !do_write) begin
        count <= count - 1'b1;
      end
    end
  end

  // Storage array
  always_ff @(posedge clk_axi) begin
    if (do_write) begin
      mem[wr_ptr] <= data_i;
    end
  end

endmodule

// File: verilog/axi_ni_pkg.sv
// Shared widths, AXI channel structs, enums and the VC address decode for the NI slave
package axi_ni_pkg;

  // ***********************************************************
  // Widths and address map
  // ***********************************************************
  localparam int AxiDataWidth = 64;
  localparam int AxiAddrWidth = 16;
  localparam int AxiIdWidth   = 4;
  localparam int AxiLenWidth  = 8;
  localparam int MaxVcWidth   = 2;
  localparam int MaxVc        = 2 ** MaxVcWidth;

  localparam logic [AxiAddrWidth-1:0] WrVcBase = 16'h1000;
  localparam logic [AxiAddrWidth-1:0] RdVcBase = 16'h2000;
  localparam int unsigned             VcStride = 8;

  typedef enum logic [1:0] {
    BURST_FIXED = 2'b00,
    BURST_INCR  = 2'b01,
    BURST_WRAP  = 2'b10
  } axi_burst_e;

  typedef enum logic [1:0] {
    RESP_OKAY   = 2'b00,
    RESP_EXOKAY = 2'b01,
    RESP_SLVERR = 2'b10,
    RESP_DECERR = 2'b11
  } axi_resp_e;

  typedef enum logic [1:0] {
    REGION_NONE  = 2'b00,
    REGION_WR_VC = 2'b01,
    REGION_RD_VC = 2'b10
  } ni_region_e;

  // ***********************************************************
  // Channel payloads
  // ***********************************************************
  typedef struct packed {
    logic [AxiIdWidth-1:0]   id;
    logic [AxiAddrWidth-1:0] addr;
    logic [AxiLenWidth-1:0]  len;
    logic [2:0]              size;
    axi_burst_e              burst;
  } axi_aw_t;

  typedef axi_aw_t axi_ar_t;

  typedef struct packed {
    logic [AxiDataWidth-1:0] data;
    logic                    last;
  } axi_w_t;

  typedef struct packed {
    logic [AxiIdWidth-1:0] id;
    axi_resp_e             resp;
  } axi_b_t;

  typedef struct packed {
    logic [AxiIdWidth-1:0]   id;
    logic [AxiDataWidth-1:0] data;
    axi_resp_e               resp;
    logic                    last;
  } axi_r_t;

  // One outstanding burst as kept in a request queue
  typedef struct packed {
    logic [AxiIdWidth-1:0]  id;
    logic [AxiLenWidth-1:0] len;
    logic [MaxVcWidth-1:0]  vc;
    logic                   error;
  } ot_entry_t;

  // Flit toward the packet generator
  typedef struct packed {
    logic                    valid;
    logic [MaxVcWidth-1:0]   vc;
    logic                    head;
    logic                    last;
    logic [AxiLenWidth-1:0]  len;
    logic [AxiDataWidth-1:0] data;
  } pkt_out_t;

  // Flit arriving from the NoC
  typedef struct packed {
    logic                    valid;
    logic [MaxVcWidth-1:0]   vc;
    logic [AxiDataWidth-1:0] data;
  } pkt_in_t;

  typedef struct packed {
    ni_region_e            region;
    logic [MaxVcWidth-1:0] vc;
  } ni_dec_t;

  // Maps a burst onto a write or read VC, REGION_NONE when anything is off
  function automatic ni_dec_t decode_region(input logic [AxiAddrWidth-1:0] addr,
                                            input int unsigned             num_vc,
                                            input axi_burst_e              burst,
                                            input logic [2:0]              size);
    ni_dec_t dec;
    dec.region = REGION_NONE;
    dec.vc     = '0;
    // Only 8-byte INCR bursts are served
    if ((burst == BURST_INCR) && (size == 3'd3)) begin
      for (int unsigned v = 0; v < MaxVc; v++) begin
        if (v < num_vc) begin
          if (addr == WrVcBase + AxiAddrWidth'(v * VcStride)) begin
            dec.region = REGION_WR_VC;
            dec.vc     = MaxVcWidth'(v);
          end
          if (addr == RdVcBase + AxiAddrWidth'(v * VcStride)) begin
            dec.region = REGION_RD_VC;
            dec.vc     = MaxVcWidth'(v);
          end
        end
      end
    end
    return dec;
  endfunction

endpackage
